// ==== rtl/arith_pkg.sv ====
/*
  Request side of the 16-bit add and subtract unit.
  The width is fixed because the prefix network has exactly four levels.
  Operation codes are two bits and must stay in step with operand_prep.
*/
package arith_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Operand and result width, one word
    localparam int data_width = 16;

    // Prefix levels needed to span data_width bits
    localparam int prefix_levels = 4;

    ////////////////////
    // Operations
    ////////////////////

    // Chained forms read the stored carry flag
    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_sub = 2'b01,
        op_adc = 2'b10,
        op_sbc = 2'b11
    } op_e;

    ////////////////////
    // Request
    ////////////////////

    // One request, 34 bits
    typedef struct packed {
        op_e                   op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
    } req_t;

endpackage

// ==== rtl/result_pkg.sv ====
/*
  Result side of the add and subtract unit.
  Carry follows the no-borrow convention for subtraction.
*/
package result_pkg;

    ////////////////////
    // Flags
    ////////////////////

    // Carry is 1 when a subtraction did not borrow
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } flags_t;

    ////////////////////
    // Result
    ////////////////////

    // Sum and its flags, 20 bits
    typedef struct packed {
        logic [arith_pkg::data_width-1:0] sum;
        flags_t                           flags;
    } result_t;

endpackage

// ==== rtl/pipe_stage.sv ====
/*
  One pipeline register with a valid bit, for any packed payload type.
  Only the valid bit is reset. The payload holds its last value while idle.
*/
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload loads only with a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== rtl/operand_prep.sv ====
/*
  Maps a registered request onto adder operands and carry-in.
  Subtraction is done as a + ~b + cin, so carry out means no borrow.
  The stored carry is only looked at by adc and sbc.
*/
module operand_prep (
    input  arith_pkg::req_t                  req,
    input  logic                             carry_q,
    output logic [arith_pkg::data_width-1:0] op_a,
    output logic [arith_pkg::data_width-1:0] op_b,
    output logic                             cin
);

    logic invert_b;

    // Operation decode
    always_comb begin
        invert_b = 1'b0;
        cin      = 1'b0;
        case (req.op)
            arith_pkg::op_add: begin
                invert_b = 1'b0;
                cin      = 1'b0;
            end
            arith_pkg::op_sub: begin
                // Two's complement negate of b
                invert_b = 1'b1;
                cin      = 1'b1;
            end
            arith_pkg::op_adc: begin
                invert_b = 1'b0;
                cin      = carry_q;
            end
            arith_pkg::op_sbc: begin
                // Borrow pending when carry_q is 0
                invert_b = 1'b1;
                cin      = carry_q;
            end
            default: begin
                invert_b = 1'b0;
                cin      = 1'b0;
            end
        endcase
    end

    assign op_a = req.a;
    assign op_b = invert_b ? ~req.b : req.b;

endmodule

// ==== rtl/kogge_stone_adder.sv ====
/*
  Combinational Kogge-Stone adder, fixed at 16 bits and four prefix levels.
  The carry-in acts as the generate of bit -1 and is merged into bit 0
  before the prefix network, so bit 15 sees all carries after level four.
*/
module kogge_stone_adder (
    input  logic [arith_pkg::data_width-1:0] a,
    input  logic [arith_pkg::data_width-1:0] b,
    input  logic                             cin,
    output logic [arith_pkg::data_width-1:0] sum,
    output logic                             cout
);

    localparam int w      = arith_pkg::data_width;
    localparam int levels = arith_pkg::prefix_levels;

    // Per-bit terms
    logic [w-1:0] gen_bit;
    logic [w-1:0] prop_bit;
    logic [w-1:0] half_sum;

    // Group generate after each level, index 0 is preprocessing
    logic [w-1:0] grp_g [0:levels];
    // Group propagate, the last level needs none
    logic [w-1:0] grp_p [0:levels-1];

    ////////////////////
    // Preprocessing
    ////////////////////

    assign gen_bit  = a & b;
    assign prop_bit = a | b;
    assign half_sum = a ^ b;

    // Bit 0 absorbs the carry-in as its lower neighbour
    assign grp_g[0][0] = gen_bit[0] | (prop_bit[0] & cin);
    assign grp_p[0][0] = 1'b0;

    genvar i;
    genvar lvl;

    generate
        for (i = 1; i < w; i = i + 1) begin : gen_pre
            assign grp_g[0][i] = gen_bit[i];
            assign grp_p[0][i] = prop_bit[i];
        end
    endgenerate

    ////////////////////
    // Prefix network
    ////////////////////

    // Spans of 1, 2, 4 and 8
    generate
        for (lvl = 0; lvl < levels; lvl = lvl + 1) begin : gen_level
            localparam int span = 1 << lvl;
            for (i = 0; i < w; i = i + 1) begin : gen_cell
                if (i < span) begin : gen_pass
                    // Already complete down to bit -1
                    assign grp_g[lvl+1][i] = grp_g[lvl][i];
                    if (lvl < levels - 1) begin : gen_pass_p
                        assign grp_p[lvl+1][i] = grp_p[lvl][i];
                    end
                end else begin : gen_dot
                    assign grp_g[lvl+1][i] = grp_g[lvl][i]
                                           | (grp_p[lvl][i] & grp_g[lvl][i-span]);
                    if (lvl < levels - 1) begin : gen_dot_p
                        assign grp_p[lvl+1][i] = grp_p[lvl][i] & grp_p[lvl][i-span];
                    end
                end
            end
        end
    endgenerate

    ////////////////////
    // Sum and carry out
    ////////////////////

    assign sum[0] = half_sum[0] ^ cin;

    generate
        for (i = 1; i < w; i = i + 1) begin : gen_sum
            assign sum[i] = half_sum[i] ^ grp_g[levels][i-1];
        end
    endgenerate

    assign cout = grp_g[levels][w-1];

endmodule

// ==== rtl/flag_unit.sv ====
/*
  Builds the result flags and keeps the carry used by adc and sbc.
  op_b must be the adder's input, already inverted for subtraction,
  so one overflow rule covers all four operations.
  The carry register clears to 0 on reset.
*/
module flag_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             s1_valid,
    input  logic [arith_pkg::data_width-1:0] sum,
    input  logic                             cout,
    input  logic [arith_pkg::data_width-1:0] op_a,
    input  logic [arith_pkg::data_width-1:0] op_b,
    output logic                             carry_q,
    output result_pkg::result_t              result
);

    localparam int msb = arith_pkg::data_width - 1;

    result_pkg::flags_t flags;

    ////////////////////
    // Flags
    ////////////////////

    always_comb begin
        flags.zero     = (sum == '0);
        flags.negative = sum[msb];
        flags.carry    = cout;
        // Same operand signs, different result sign
        flags.overflow = (op_a[msb] == op_b[msb]) && (sum[msb] != op_a[msb]);
    end

    assign result.sum   = sum;
    assign result.flags = flags;

    ////////////////////
    // Carry register
    ////////////////////

    // Written at the edge that moves the next request into stage one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (s1_valid) begin
            carry_q <= cout;
        end
    end

endmodule

// ==== rtl/adder_unit.sv ====
/*
  Pipelined 16-bit add and subtract unit, two cycles from req_valid to res_valid.
  One request per cycle is accepted and there is no back-pressure.
  Chained adc and sbc may follow their first half on the very next cycle.
*/
module adder_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  arith_pkg::req_t     req,
    output logic                res_valid,
    output result_pkg::result_t res
);

    // Stage one
    logic                             s1_valid;
    arith_pkg::req_t                  s1_req;

    // Adder path
    logic [arith_pkg::data_width-1:0] op_a;
    logic [arith_pkg::data_width-1:0] op_b;
    logic                             cin;
    logic [arith_pkg::data_width-1:0] sum;
    logic                             cout;

    logic                             carry_q;
    result_pkg::result_t              s1_result;

    pipe_stage #(
        .payload_t(arith_pkg::req_t)
    ) req_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (req_valid),
        .in_data  (req),
        .out_valid(s1_valid),
        .out_data (s1_req)
    );

    operand_prep operand_prep_inst (
        .req    (s1_req),
        .carry_q(carry_q),
        .op_a   (op_a),
        .op_b   (op_b),
        .cin    (cin)
    );

    kogge_stone_adder kogge_stone_adder_inst (
        .a   (op_a),
        .b   (op_b),
        .cin (cin),
        .sum (sum),
        .cout(cout)
    );

    flag_unit flag_unit_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .s1_valid(s1_valid),
        .sum     (sum),
        .cout    (cout),
        .op_a    (op_a),
        .op_b    (op_b),
        .carry_q (carry_q),
        .result  (s1_result)
    );

    pipe_stage #(
        .payload_t(result_pkg::result_t)
    ) res_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (s1_valid),
        .in_data  (s1_result),
        .out_valid(res_valid),
        .out_data (res)
    );

endmodule

// ==== tb/adder_unit_properties.sv ====
/*
  Concurrent checks bound into adder_unit.
  Covers the reset state, the two-cycle latency and the strobe rule.
*/
module adder_unit_properties (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic res_valid,
    input logic carry_q
);

    ////////////////////
    // Reset
    ////////////////////

    res_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !res_valid
    ) else $error("res_valid high in the cycle after reset");

    carry_clear_after_reset: assert property (
        @(posedge clk) !rst_n |=> !carry_q
    ) else $error("carry register not cleared by reset");

    ////////////////////
    // Latency
    ////////////////////

    // Each strobe gives a result strobe two cycles later
    req_gives_res: assert property (
        @(posedge clk) disable iff (!rst_n) req_valid |-> ##2 res_valid
    ) else $error("res_valid missing two cycles after req_valid");

    // And no result strobe appears without one
    idle_gives_no_res: assert property (
        @(posedge clk) disable iff (!rst_n) !req_valid |-> ##2 !res_valid
    ) else $error("res_valid high without a request two cycles before");

endmodule

bind adder_unit adder_unit_properties adder_unit_properties_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .res_valid(res_valid),
    .carry_q  (carry_q)
);

// ==== tb/adder_unit_tb.sv ====
/*
  Testbench for adder_unit: a directed table, then a seeded random phase.
  Expected values come from hand-worked rows and a behavioral model.
  Results are sampled on the falling edge and must arrive two cycles after each strobe.
*/
module adder_unit_tb;

    localparam int table_len       = 16;
    localparam int rand_cycles     = 300;
    localparam int period          = 100;
    localparam int watchdog_cycles = table_len + rand_cycles + 20;

    typedef struct packed {
        arith_pkg::op_e                   op;
        logic [arith_pkg::data_width-1:0] a;
        logic [arith_pkg::data_width-1:0] b;
        logic [arith_pkg::data_width-1:0] exp_sum;
        result_pkg::flags_t               exp_flags;
    } vector_t;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    arith_pkg::req_t     req;
    logic                res_valid;
    result_pkg::result_t res;

    vector_t             vectors [0:table_len-1];
    result_pkg::result_t exp_q [$];
    int                  due_q [$];
    result_pkg::result_t exp_res;
    result_pkg::result_t row_res;
    result_pkg::result_t model_res;
    int                  due;
    int                  cycle_count;
    int                  value_errors;
    int                  protocol_errors;
    int                  drain_wait;
    integer              seed;
    logic [31:0]         rnd;
    logic                model_carry;

    adder_unit adder_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(req_valid),
        .req      (req),
        .res_valid(res_valid),
        .res      (res)
    );

    always #(period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic set_row(input int idx, input arith_pkg::op_e op,
                           input logic [15:0] a, input logic [15:0] b,
                           input logic [15:0] exp_sum, input logic [3:0] exp_flags);
        vectors[idx].op        = op;
        vectors[idx].a         = a;
        vectors[idx].b         = b;
        vectors[idx].exp_sum   = exp_sum;
        vectors[idx].exp_flags = exp_flags;
    endtask

    // Drive on the current falling edge, then move to the next one
    task automatic issue_request(input arith_pkg::op_e op, input logic [15:0] a,
                                 input logic [15:0] b, input result_pkg::result_t exp);
        req_valid = 1'b1;
        req.op    = op;
        req.a     = a;
        req.b     = b;
        exp_q.push_back(exp);
        // Due at the falling edge after the second rising edge from now
        due_q.push_back(cycle_count + 2);
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        req_valid = 1'b0;
        @(negedge clk);
    endtask

    // Wide addition with b inverted for subtraction, carry 1 means no borrow
    function automatic result_pkg::result_t model_result(input arith_pkg::op_e op,
                                                         input logic [15:0] a,
                                                         input logic [15:0] b,
                                                         input logic carry_state);
        logic [15:0]         b_eff;
        logic                cin;
        logic [16:0]         wide;
        int                  sval;
        result_pkg::result_t r;
        b_eff = b;
        cin   = carry_state;
        if (op == arith_pkg::op_sub || op == arith_pkg::op_sbc) begin
            b_eff = ~b;
        end
        if (op == arith_pkg::op_add) begin
            cin = 1'b0;
        end else if (op == arith_pkg::op_sub) begin
            cin = 1'b1;
        end
        wide = {1'b0, a} + {1'b0, b_eff} + {16'b0, cin};
        // True signed result, checked against the 16-bit range
        sval = int'($signed(a)) + int'($signed(b_eff)) + int'(cin);
        r.sum            = wide[15:0];
        r.flags.zero     = (wide[15:0] == 16'h0000);
        r.flags.negative = wide[15];
        r.flags.carry    = wide[16];
        r.flags.overflow = (sval > 32767) || (sval < -32768);
        return r;
    endfunction

    ////////////////////
    // Result monitor
    ////////////////////

    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("Result at time %0t with no outstanding request", $time);
                protocol_errors++;
            end else begin
                exp_res = exp_q.pop_front();
                due     = due_q.pop_front();
                if (res.sum !== exp_res.sum) begin
                    $display("[ERROR] t=%0t res.sum got %h expected %h",
                             $time, res.sum, exp_res.sum);
                    value_errors++;
                end
                if (res.flags !== exp_res.flags) begin
                    $display("[ERROR] t=%0t res.flags got %b expected %b",
                             $time, res.flags, exp_res.flags);
                    value_errors++;
                end
                if (cycle_count != due) begin
                    $display("Result at time %0t arrived at cycle %0d instead of cycle %0d",
                             $time, cycle_count, due);
                    protocol_errors++;
                end
            end
        end
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        #(watchdog_cycles * period);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req             = '0;
        cycle_count     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        seed            = 32'hbcb4_baaf;
        model_carry     = 1'b0;

        // Flags are zero, negative, carry, overflow
        set_row(0,  arith_pkg::op_adc, 16'h1234, 16'h0001, 16'h1235, 4'b0000);
        set_row(1,  arith_pkg::op_add, 16'hffff, 16'h0001, 16'h0000, 4'b1010);
        set_row(2,  arith_pkg::op_add, 16'h7fff, 16'h0001, 16'h8000, 4'b0101);
        set_row(3,  arith_pkg::op_sub, 16'h8000, 16'h0001, 16'h7fff, 4'b0011);
        set_row(4,  arith_pkg::op_sub, 16'h1234, 16'h1234, 16'h0000, 4'b1010);
        set_row(5,  arith_pkg::op_sub, 16'h0005, 16'h0007, 16'hfffe, 4'b0100);
        set_row(6,  arith_pkg::op_add, 16'h8000, 16'h7fff, 16'hffff, 4'b0100);
        set_row(7,  arith_pkg::op_add, 16'hfff0, 16'h0020, 16'h0010, 4'b0010);
        // 32-bit 0x1234_f000 + 0x0001_2000
        set_row(8,  arith_pkg::op_add, 16'hf000, 16'h2000, 16'h1000, 4'b0010);
        set_row(9,  arith_pkg::op_adc, 16'h1234, 16'h0001, 16'h1236, 4'b0000);
        // 32-bit 0x0005_0000 - 0x0001_0001
        set_row(10, arith_pkg::op_sub, 16'h0000, 16'h0001, 16'hffff, 4'b0100);
        set_row(11, arith_pkg::op_sbc, 16'h0005, 16'h0001, 16'h0003, 4'b0010);
        set_row(12, arith_pkg::op_sbc, 16'h0003, 16'h0003, 16'h0000, 4'b1010);
        set_row(13, arith_pkg::op_adc, 16'h7ffe, 16'h0000, 16'h7fff, 4'b0000);
        set_row(14, arith_pkg::op_adc, 16'h8000, 16'h8000, 16'h0000, 4'b1011);
        set_row(15, arith_pkg::op_sbc, 16'h0000, 16'h0000, 16'h0000, 4'b1010);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Directed rows back to back, the first one right after reset
        for (int i = 0; i < table_len; i++) begin
            row_res.sum   = vectors[i].exp_sum;
            row_res.flags = vectors[i].exp_flags;
            model_carry   = vectors[i].exp_flags.carry;
            issue_request(vectors[i].op, vectors[i].a, vectors[i].b, row_res);
        end

        // Mixed operations with idle gaps about one cycle in four
        for (int i = 0; i < rand_cycles; i++) begin
            rnd = $random(seed);
            if (rnd[3:2] == 2'b00) begin
                idle_cycle();
            end else begin
                req.op    = arith_pkg::op_e'(rnd[1:0]);
                rnd       = $random(seed);
                model_res = model_result(req.op, rnd[15:0], rnd[31:16], model_carry);
                model_carry = model_res.flags.carry;
                issue_request(req.op, rnd[15:0], rnd[31:16], model_res);
            end
        end

        req_valid  = 1'b0;
        drain_wait = 0;
        while (exp_q.size() != 0 && drain_wait < 10) begin
            @(negedge clk);
            drain_wait++;
        end
        repeat (2) @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d requests never returned a result", exp_q.size());
            protocol_errors++;
        end

        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/arith_pkg.sv
rtl/result_pkg.sv
rtl/pipe_stage.sv
rtl/operand_prep.sv
rtl/kogge_stone_adder.sv
rtl/flag_unit.sv
rtl/adder_unit.sv
tb/adder_unit_properties.sv
tb/adder_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the adder_unit testbench

VERILATOR ?= verilator
TOP       ?= adder_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only if the pass message shows up in the simulation output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
